//--- Bender.yml
package:
  name: rename_core

sources:
  - files:
      - rtl/rename_pkg.sv
      - rtl/chkp_if.sv
      - rtl/free_list.sv
      - rtl/rename_table.sv
      - rtl/graduation_list.sv
      - rtl/rename_core.sv
  - target: test
    files:
      - test/rename_core_props.sv
      - test/tb_rename_core.sv

//--- rtl/chkp_if.sv
// Branch checkpoint control bus
// Shared by the rename control, the rename table and the free list
`timescale 1ns/1ps
`default_nettype none

interface chkp_if #(
    parameter int NUM_CHECKPOINTS = 4
);

    localparam int CHKP_W = (NUM_CHECKPOINTS > 1) ? $clog2(NUM_CHECKPOINTS) : 1;

    // Commands from the rename control
    logic              do_checkpoint;
    logic              do_recover;
    logic              delete_checkpoint;

    // Slot bookkeeping owned by the rename table
    logic [CHKP_W-1:0] checkpoint_id;
    logic [CHKP_W-1:0] oldest_id;
    logic              out_of_checkpoints;

    modport ctrl (
        output do_checkpoint, do_recover, delete_checkpoint,
        input  out_of_checkpoints
    );

    modport tbl (
        input  do_checkpoint, do_recover, delete_checkpoint,
        output checkpoint_id, oldest_id, out_of_checkpoints
    );

    modport list (
        input  do_checkpoint, do_recover, delete_checkpoint, checkpoint_id, oldest_id
    );

endinterface

`default_nettype wire

//--- rtl/free_list.sv
// Free list of physical registers
// Circular FIFO with a saved head per branch checkpoint
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,
    input  wire logic              alloc_i,
    input  wire logic              free_i,
    input  wire rename_pkg::phreg_t free_reg_i,
    chkp_if.list                   chkp,
    output rename_pkg::phreg_t     new_reg_o,
    output logic                   empty_o
);

    // Only registers beyond the architectural set ever sit here
    localparam int FL_DEPTH = rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);
    // Extra wrap bit tells a full list from an empty one
    localparam int PTR_W    = FL_W + 1;

    rename_pkg::phreg_t fifo_q [FL_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] head_d;
    logic [PTR_W-1:0] count;

    logic [PTR_W-1:0] head_chkp_q [NUM_CHECKPOINTS];

    ////////////////////////////////////////////////////////////
    // Occupancy and head

    assign count     = tail_q - head_q;
    assign empty_o   = (count == '0);
    assign new_reg_o = fifo_q[head_q[FL_W-1:0]];

    // Head after this cycle's allocation
    assign head_d = head_q + PTR_W'(alloc_i);

    ////////////////////////////////////////////////////////////
    // FIFO storage and pointers

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            // Start with every non-architectural register free, ascending
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::phreg_t'(rename_pkg::NUM_ARCH_REGS + i);
            end
            head_q <= '0;
            tail_q <= PTR_W'(FL_DEPTH);
        end else begin
            if (chkp.do_recover) begin
                head_q <= head_chkp_q[chkp.oldest_id];
            end else begin
                head_q <= head_d;
            end
            // Registers released at commit go to the tail
            if (free_i) begin
                fifo_q[tail_q[FL_W-1:0]] <= free_reg_i;
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Head snapshots

    // Snapshot includes the branch's own allocation
    always_ff @(posedge clk_i) begin
        if (chkp.do_checkpoint) begin
            head_chkp_q[chkp.checkpoint_id] <= head_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/graduation_list.sv
// Graduation list
// Reorder buffer with out-of-order completion and in-order commit
`timescale 1ns/1ps
`default_nettype none

module graduation_list #(
    parameter int GL_DEPTH = 16
) (
    input  wire logic                          clk_i,
    input  wire logic                          rstn_i,
    input  wire logic                          alloc_i,
    input  wire rename_pkg::gl_entry_t         entry_i,
    input  wire logic                          complete_i,
    input  wire logic [$clog2(GL_DEPTH)-1:0]   complete_index_i,
    input  wire logic                          truncate_i,
    input  wire logic [$clog2(GL_DEPTH)-1:0]   truncate_index_i,
    output logic [$clog2(GL_DEPTH)-1:0]        alloc_index_o,
    output logic                               full_o,
    output rename_pkg::gl_entry_t              head_o,
    output logic                               head_valid_o,
    output logic                               commit_o
);

    localparam int IDX_W = $clog2(GL_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    rename_pkg::gl_entry_t entries_q [GL_DEPTH];

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    // Entries kept on truncation, the branch included
    logic [CNT_W-1:0] keep_cnt;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(GL_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign head_o        = entries_q[head_q];
    assign head_valid_o  = (count_q != '0);
    assign commit_o      = head_valid_o && head_o.done;
    assign full_o        = (count_q == CNT_W'(GL_DEPTH));
    assign alloc_index_o = tail_q;

    // Distance from head to the branch, wrapping around the ring
    always_comb begin
        if (truncate_index_i >= head_q) begin
            keep_cnt = CNT_W'(truncate_index_i) - CNT_W'(head_q) + 1'b1;
        end else begin
            keep_cnt = CNT_W'(truncate_index_i) + CNT_W'(GL_DEPTH) - CNT_W'(head_q) + 1'b1;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < GL_DEPTH; i++) begin
                entries_q[i] <= '0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (complete_i) begin
                entries_q[complete_index_i].done <= 1'b1;
            end
            // A fresh entry overrides a stale completion on the same slot
            if (alloc_i && !truncate_i) begin
                entries_q[tail_q] <= entry_i;
            end
            if (commit_o) begin
                head_q <= next_idx(head_q);
            end
            if (truncate_i) begin
                tail_q  <= next_idx(truncate_index_i);
                count_q <= keep_cnt - CNT_W'(commit_o);
            end else begin
                if (alloc_i) begin
                    tail_q <= next_idx(tail_q);
                end
                count_q <= count_q + CNT_W'(alloc_i) - CNT_W'(commit_o);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rename_core.sv
// Register renaming back end
// Rename table, free list and graduation list with branch recovery
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
    parameter int NUM_CHECKPOINTS = rename_pkg::DEFAULT_NUM_CHECKPOINTS,
    parameter int GL_DEPTH        = rename_pkg::DEFAULT_GL_DEPTH
) (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    // Rename input
    input  wire logic                        instr_valid_i,
    input  wire rename_pkg::arch_reg_t       rs1_i,
    input  wire rename_pkg::arch_reg_t       rs2_i,
    input  wire rename_pkg::arch_reg_t       rd_i,
    input  wire logic                        we_i,
    input  wire logic                        is_branch_i,
    output logic                             ready_o,
    // Rename output
    output logic                             ren_valid_o,
    output rename_pkg::phreg_t               prs1_o,
    output rename_pkg::phreg_t               prs2_o,
    output rename_pkg::phreg_t               prd_o,
    output rename_pkg::phreg_t               old_prd_o,
    output logic [$clog2(GL_DEPTH)-1:0]      gl_index_o,
    // Completion
    input  wire logic                        complete_valid_i,
    input  wire logic [$clog2(GL_DEPTH)-1:0] complete_index_i,
    // Branch resolution
    input  wire logic                        branch_valid_i,
    input  wire logic                        branch_mispredict_i,
    input  wire logic [$clog2(GL_DEPTH)-1:0] branch_gl_index_i,
    // Commit
    output logic                             commit_valid_o,
    output rename_pkg::arch_reg_t            commit_rd_o,
    output logic                             commit_we_o,
    output rename_pkg::phreg_t               commit_prd_o,
    output rename_pkg::phreg_t               commit_old_prd_o
);

    localparam int GL_IDX_W = $clog2(GL_DEPTH);

    chkp_if #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) chkp ();

    logic                  writes_reg;
    logic                  mispredict;
    logic                  accept;
    logic                  alloc;
    logic                  fl_empty;
    logic                  gl_full;
    logic                  gl_commit;
    logic [GL_IDX_W-1:0]   gl_alloc_index;
    rename_pkg::phreg_t    fl_new_reg;
    rename_pkg::phreg_t    map_prs1;
    rename_pkg::phreg_t    map_prs2;
    rename_pkg::phreg_t    map_old_prd;
    rename_pkg::phreg_t    new_prd;
    rename_pkg::phreg_t    disp_prd;
    rename_pkg::gl_entry_t gl_entry;
    rename_pkg::gl_entry_t gl_head;

    ////////////////////////////////////////////////////////////
    // Acceptance and checkpoint control

    // x0 is never renamed
    assign writes_reg = we_i && (rd_i != '0);
    assign mispredict = branch_valid_i && branch_mispredict_i;

    assign ready_o = !gl_full
                  && !(writes_reg && fl_empty)
                  && !(is_branch_i && chkp.out_of_checkpoints)
                  && !mispredict;

    assign accept = instr_valid_i && ready_o;
    assign alloc  = accept && writes_reg;

    assign chkp.do_checkpoint     = accept && is_branch_i;
    assign chkp.do_recover        = mispredict;
    assign chkp.delete_checkpoint = branch_valid_i && !branch_mispredict_i;

    assign new_prd  = alloc ? fl_new_reg : '0;
    assign disp_prd = alloc ? map_old_prd : '0;

    ////////////////////////////////////////////////////////////
    // Rename structures

    rename_table #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) i_rename_table (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .rd_i      (rd_i),
        .write_i   (alloc),
        .new_prd_i (fl_new_reg),
        .chkp      (chkp),
        .prs1_o    (map_prs1),
        .prs2_o    (map_prs2),
        .old_prd_o (map_old_prd)
    );

    // Committed writers hand their displaced register back
    free_list #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) i_free_list (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .alloc_i    (alloc),
        .free_i     (gl_commit && gl_head.we),
        .free_reg_i (gl_head.old_prd),
        .chkp       (chkp),
        .new_reg_o  (fl_new_reg),
        .empty_o    (fl_empty)
    );

    always_comb begin
        gl_entry         = '0;
        gl_entry.rd      = rd_i;
        gl_entry.we      = writes_reg;
        gl_entry.prd     = new_prd;
        gl_entry.old_prd = disp_prd;
    end

    // Mispredict drops everything younger than the branch
    graduation_list #(.GL_DEPTH(GL_DEPTH)) i_graduation_list (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .alloc_i          (accept),
        .entry_i          (gl_entry),
        .complete_i       (complete_valid_i),
        .complete_index_i (complete_index_i),
        .truncate_i       (mispredict),
        .truncate_index_i (branch_gl_index_i),
        .alloc_index_o    (gl_alloc_index),
        .full_o           (gl_full),
        .head_o           (gl_head),
        .head_valid_o     (),
        .commit_o         (gl_commit)
    );

    ////////////////////////////////////////////////////////////
    // Rename output register

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            ren_valid_o <= 1'b0;
            prs1_o      <= '0;
            prs2_o      <= '0;
            prd_o       <= '0;
            old_prd_o   <= '0;
            gl_index_o  <= '0;
        end else begin
            ren_valid_o <= accept;
            // Payload only moves with an accepted instruction
            if (accept) begin
                prs1_o     <= map_prs1;
                prs2_o     <= map_prs2;
                prd_o      <= new_prd;
                old_prd_o  <= disp_prd;
                gl_index_o <= gl_alloc_index;
            end
        end
    end

    // Commit straight from the head entry
    assign commit_valid_o   = gl_commit;
    assign commit_rd_o      = gl_head.rd;
    assign commit_we_o      = gl_head.we;
    assign commit_prd_o     = gl_head.prd;
    assign commit_old_prd_o = gl_head.old_prd;

endmodule

`default_nettype wire

//--- rtl/rename_pkg.sv
// Register renaming back end shared definitions
// Register index types, structure sizes and the graduation entry
`default_nettype none

package rename_pkg;

    // Architectural and physical register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phreg_t;

    // Defaults for the top-level parameters
    localparam int DEFAULT_NUM_CHECKPOINTS = 4;
    localparam int DEFAULT_GL_DEPTH        = 16;

    // One reorder buffer slot
    typedef struct packed {
        arch_reg_t rd;
        logic      we;
        phreg_t    prd;
        phreg_t    old_prd;
        logic      done;
    } gl_entry_t;

endpackage

`default_nettype wire

//--- rtl/rename_table.sv
// Rename table
// Speculative architectural to physical map with branch checkpoints
`timescale 1ns/1ps
`default_nettype none

module rename_table #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire rename_pkg::arch_reg_t rs1_i,
    input  wire rename_pkg::arch_reg_t rs2_i,
    input  wire rename_pkg::arch_reg_t rd_i,
    input  wire logic                  write_i,
    input  wire rename_pkg::phreg_t    new_prd_i,
    chkp_if.tbl                        chkp,
    output rename_pkg::phreg_t         prs1_o,
    output rename_pkg::phreg_t         prs2_o,
    output rename_pkg::phreg_t         old_prd_o
);

    localparam int CHKP_W = (NUM_CHECKPOINTS > 1) ? $clog2(NUM_CHECKPOINTS) : 1;
    localparam int CNT_W  = $clog2(NUM_CHECKPOINTS + 1);

    rename_pkg::phreg_t map_q [rename_pkg::NUM_ARCH_REGS];
    rename_pkg::phreg_t map_d [rename_pkg::NUM_ARCH_REGS];
    rename_pkg::phreg_t chkp_map_q [NUM_CHECKPOINTS][rename_pkg::NUM_ARCH_REGS];

    logic [CHKP_W-1:0] wr_ptr_q;
    logic [CHKP_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  count_q;

    function automatic logic [CHKP_W-1:0] next_ptr(input logic [CHKP_W-1:0] ptr);
        return (ptr == CHKP_W'(NUM_CHECKPOINTS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Source lookups
    assign prs1_o    = map_q[rs1_i];
    assign prs2_o    = map_q[rs2_i];
    assign old_prd_o = map_q[rd_i];

    // Map as it looks after this cycle's write, x0 stays fixed
    always_comb begin
        map_d = map_q;
        if (write_i && (rd_i != '0)) begin
            map_d[rd_i] = new_prd_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phreg_t'(i);
            end
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (chkp.do_recover) begin
            // Roll back to the oldest branch and drop every checkpoint
            map_q    <= chkp_map_q[chkp.oldest_id];
            wr_ptr_q <= rd_ptr_q;
            count_q  <= '0;
        end else begin
            map_q <= map_d;
            if (chkp.do_checkpoint) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (chkp.delete_checkpoint) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(chkp.do_checkpoint) - CNT_W'(chkp.delete_checkpoint);
        end
    end

    // Checkpoint copies
    always_ff @(posedge clk_i) begin
        if (chkp.do_checkpoint) begin
            chkp_map_q[chkp.checkpoint_id] <= map_d;
        end
    end

    assign chkp.checkpoint_id      = wr_ptr_q;
    assign chkp.oldest_id          = rd_ptr_q;
    assign chkp.out_of_checkpoints = (count_q == CNT_W'(NUM_CHECKPOINTS));

endmodule

`default_nettype wire

//--- sim.f
rtl/rename_pkg.sv
rtl/chkp_if.sv
rtl/free_list.sv
rtl/rename_table.sv
rtl/graduation_list.sv
rtl/rename_core.sv
test/rename_core_props.sv
test/tb_rename_core.sv

//--- test/rename_core_props.sv
// Port properties of the register renaming back end
// Bound to every rename_core instance
`timescale 1ns/1ps
`default_nettype none

module rename_core_props #(
    parameter int GL_DEPTH = rename_pkg::DEFAULT_GL_DEPTH
) (
    input wire logic                        clk_i,
    input wire logic                        rstn_i,
    input wire logic                        ready_o,
    input wire logic                        ren_valid_o,
    input wire rename_pkg::phreg_t          prs1_o,
    input wire rename_pkg::phreg_t          prs2_o,
    input wire rename_pkg::phreg_t          prd_o,
    input wire rename_pkg::phreg_t          old_prd_o,
    input wire logic [$clog2(GL_DEPTH)-1:0] gl_index_o,
    input wire logic                        commit_valid_o,
    input wire rename_pkg::arch_reg_t       commit_rd_o,
    input wire logic                        commit_we_o,
    input wire rename_pkg::phreg_t          commit_prd_o,
    input wire rename_pkg::phreg_t          commit_old_prd_o
);

    // Number of property failures so far
    int unsigned fail_count = 0;

    // Nothing leaves rename unless ready was high at the accepting edge
    ren_needs_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !ready_o |=> !ren_valid_o)
        else begin
            fail_count++;
            $error("Rename output after an edge with ready low");
        end

    // A committing writer never displaces its own register
    commit_regs_differ: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (commit_valid_o && commit_we_o) |-> (commit_prd_o != commit_old_prd_o))
        else begin
            fail_count++;
            $error("Committed prd equals old_prd");
        end

    outputs_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({ready_o, ren_valid_o, prs1_o, prs2_o, prd_o, old_prd_o, gl_index_o,
                     commit_valid_o, commit_rd_o, commit_we_o, commit_prd_o,
                     commit_old_prd_o}))
        else begin
            fail_count++;
            $error("Unknown value on a rename or commit output");
        end

endmodule

bind rename_core rename_core_props #(.GL_DEPTH(GL_DEPTH)) i_rename_core_props (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .ready_o          (ready_o),
    .ren_valid_o      (ren_valid_o),
    .prs1_o           (prs1_o),
    .prs2_o           (prs2_o),
    .prd_o            (prd_o),
    .old_prd_o        (old_prd_o),
    .gl_index_o       (gl_index_o),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_we_o      (commit_we_o),
    .commit_prd_o     (commit_prd_o),
    .commit_old_prd_o (commit_old_prd_o)
);

`default_nettype wire

//--- test/tb_rename_core.sv
// Testbench for the register renaming back end
// Reference model of map, free list and graduation list, random completion order
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int GL_DEPTH     = rename_pkg::DEFAULT_GL_DEPTH;
    localparam int GL_IDX_W     = $clog2(GL_DEPTH);

    // Test lengths in operations
    localparam int LEN_IDENTITY    = 9;
    localparam int LEN_DEPENDENCY  = 2;
    localparam int LEN_COMPLETE    = 11;
    localparam int LEN_RECYCLE     = 57;
    localparam int LEN_MISPREDICT  = 9;
    localparam int LEN_CHECKPOINTS = 24;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * (LEN_IDENTITY + LEN_DEPENDENCY
                                   + LEN_COMPLETE + LEN_RECYCLE + LEN_MISPREDICT
                                   + LEN_CHECKPOINTS);

    typedef rename_pkg::phreg_t [rename_pkg::NUM_ARCH_REGS-1:0] map_vec_t;

    typedef struct packed {
        logic [GL_IDX_W-1:0]   idx;
        logic                  done;
        rename_pkg::arch_reg_t rd;
        logic                  we;
        rename_pkg::phreg_t    prd;
        rename_pkg::phreg_t    old_prd;
    } model_entry_t;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  instr_valid_i;
    rename_pkg::arch_reg_t rs1_i;
    rename_pkg::arch_reg_t rs2_i;
    rename_pkg::arch_reg_t rd_i;
    logic                  we_i;
    logic                  is_branch_i;
    logic                  ready_o;
    logic                  ren_valid_o;
    rename_pkg::phreg_t    prs1_o;
    rename_pkg::phreg_t    prs2_o;
    rename_pkg::phreg_t    prd_o;
    rename_pkg::phreg_t    old_prd_o;
    logic [GL_IDX_W-1:0]   gl_index_o;
    logic                  complete_valid_i;
    logic [GL_IDX_W-1:0]   complete_index_i;
    logic                  branch_valid_i;
    logic                  branch_mispredict_i;
    logic [GL_IDX_W-1:0]   branch_gl_index_i;
    logic                  commit_valid_o;
    rename_pkg::arch_reg_t commit_rd_o;
    logic                  commit_we_o;
    rename_pkg::phreg_t    commit_prd_o;
    rename_pkg::phreg_t    commit_old_prd_o;

    // Reference model state
    map_vec_t            map_m;
    rename_pkg::phreg_t  fl_m[$];
    int                  fl_head_m;
    model_entry_t        gl_m[$];
    logic [GL_IDX_W-1:0] gl_tail_m;
    map_vec_t            chk_map_m[$];
    int                  chk_head_m[$];
    logic [GL_IDX_W-1:0] chk_idx_m[$];
    string               test_name;

    rename_core i_rename_core (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string what, input int exp, input int act);
        abort_run($sformatf("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act));
    endtask

    function automatic logic [GL_IDX_W-1:0] next_gl_idx(input logic [GL_IDX_W-1:0] idx);
        return (idx == GL_IDX_W'(GL_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus tasks

    task automatic rename_instr(input rename_pkg::arch_reg_t rs1, input rename_pkg::arch_reg_t rs2,
                                input rename_pkg::arch_reg_t rd, input logic we, input logic br);
        rename_pkg::phreg_t exp_prs1;
        rename_pkg::phreg_t exp_prs2;
        model_entry_t       ent;
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b1;
        rs1_i         = rs1;
        rs2_i         = rs2;
        rd_i          = rd;
        we_i          = we;
        is_branch_i   = br;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        // Accepted at the coming edge
        exp_prs1 = map_m[rs1];
        exp_prs2 = map_m[rs2];
        ent      = '0;
        ent.idx  = gl_tail_m;
        ent.rd   = rd;
        ent.we   = we && (rd != '0);
        if (ent.we) begin
            ent.prd     = fl_m[fl_head_m];
            ent.old_prd = map_m[rd];
            fl_head_m++;
            map_m[rd] = ent.prd;
        end
        gl_m.push_back(ent);
        gl_tail_m = next_gl_idx(gl_tail_m);
        if (br) begin
            chk_map_m.push_back(map_m);
            chk_head_m.push_back(fl_head_m);
            chk_idx_m.push_back(ent.idx);
        end
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        @(negedge clk_i);
        assert (ren_valid_o) else value_error("ren_valid", 1, ren_valid_o);
        assert (prs1_o == exp_prs1) else value_error("prs1", exp_prs1, prs1_o);
        assert (prs2_o == exp_prs2) else value_error("prs2", exp_prs2, prs2_o);
        assert (prd_o == ent.prd) else value_error("prd", ent.prd, prd_o);
        assert (old_prd_o == ent.old_prd) else value_error("old_prd", ent.old_prd, old_prd_o);
        assert (gl_index_o == ent.idx) else value_error("gl_index", ent.idx, gl_index_o);
    endtask

    task automatic expect_stalled(input string what, input rename_pkg::arch_reg_t rd,
                                  input logic br);
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b1;
        rs1_i         = '0;
        rs2_i         = '0;
        rd_i          = rd;
        we_i          = 1'b1;
        is_branch_i   = br;
        @(negedge clk_i);
        assert (!ready_o) else value_error(what, 0, ready_o);
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
    endtask

    // Resolves the oldest branch in flight
    task automatic resolve_branch(input logic mispredict);
        @(posedge clk_i);
        #1;
        assert (chk_idx_m.size() != 0) else abort_run("branch resolved with none in flight");
        branch_valid_i      = 1'b1;
        branch_mispredict_i = mispredict;
        branch_gl_index_i   = chk_idx_m[0];
        if (mispredict) begin
            map_m     = chk_map_m[0];
            fl_head_m = chk_head_m[0];
            while (gl_m[$].idx != chk_idx_m[0]) begin
                void'(gl_m.pop_back());
            end
            gl_tail_m = next_gl_idx(chk_idx_m[0]);
            chk_map_m.delete();
            chk_head_m.delete();
            chk_idx_m.delete();
        end else begin
            void'(chk_map_m.pop_front());
            void'(chk_head_m.pop_front());
            void'(chk_idx_m.pop_front());
        end
        @(posedge clk_i);
        #1;
        branch_valid_i      = 1'b0;
        branch_mispredict_i = 1'b0;
    endtask

    // Entry counts as done once the DUT has taken the completion
    function automatic void mark_done(input logic [GL_IDX_W-1:0] idx);
        foreach (gl_m[i]) begin
            if (gl_m[i].idx == idx) begin
                gl_m[i].done = 1'b1;
            end
        end
    endfunction

    // Completes every open entry in random order, then waits for the drain
    task automatic complete_all();
        logic [GL_IDX_W-1:0] order[$];
        logic [GL_IDX_W-1:0] tmp;
        int                  j;
        foreach (gl_m[i]) begin
            if (!gl_m[i].done) begin
                order.push_back(gl_m[i].idx);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            @(posedge clk_i);
            #1;
            if (k > 0) begin
                mark_done(order[k - 1]);
            end
            complete_valid_i = 1'b1;
            complete_index_i = order[k];
        end
        @(posedge clk_i);
        #1;
        if (order.size() != 0) begin
            mark_done(order[order.size() - 1]);
        end
        complete_valid_i = 1'b0;
        while (gl_m.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Commit monitor and watchdog

    always @(negedge clk_i) begin : commit_monitor
        model_entry_t head;
        if (rstn_i && commit_valid_o) begin
            assert (gl_m.size() != 0) else abort_run("commit seen with nothing in flight");
            head = gl_m.pop_front();
            assert (head.done) else abort_run("commit of an entry that never completed");
            assert (commit_rd_o == head.rd) else value_error("commit_rd", head.rd, commit_rd_o);
            assert (commit_we_o == head.we) else value_error("commit_we", head.we, commit_we_o);
            assert (commit_prd_o == head.prd)
                else value_error("commit_prd", head.prd, commit_prd_o);
            assert (commit_old_prd_o == head.old_prd)
                else value_error("commit_old_prd", head.old_prd, commit_old_prd_o);
            // Displaced register returns to the tail
            if (head.we) begin
                fl_m.push_back(head.old_prd);
            end
        end
    end

    always @(negedge clk_i) begin
        if (i_rename_core.i_rename_core_props.fail_count != 0) begin
            abort_run("A port property of the DUT failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : stimulus
        rename_pkg::phreg_t first_after;
        void'($urandom(32'h78ba));
        rstn_i              = 1'b0;
        instr_valid_i       = 1'b0;
        rs1_i               = '0;
        rs2_i               = '0;
        rd_i                = '0;
        we_i                = 1'b0;
        is_branch_i         = 1'b0;
        complete_valid_i    = 1'b0;
        complete_index_i    = '0;
        branch_valid_i      = 1'b0;
        branch_mispredict_i = 1'b0;
        branch_gl_index_i   = '0;
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            map_m[i] = rename_pkg::phreg_t'(i);
        end
        for (int i = rename_pkg::NUM_ARCH_REGS; i < rename_pkg::NUM_PHYS_REGS; i++) begin
            fl_m.push_back(rename_pkg::phreg_t'(i));
        end
        fl_head_m = 0;
        gl_tail_m = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(negedge clk_i);
        assert (ready_o) else value_error("ready", 1, ready_o);
        assert (!ren_valid_o) else value_error("ren_valid", 0, ren_valid_o);
        assert (!commit_valid_o) else value_error("commit_valid", 0, commit_valid_o);

        test_name = "identity";
        for (int i = 1; i <= 8; i++) begin
            rename_instr(5'(i), 5'(i + 8), 5'(i), 1'b1, 1'b0);
            assert (prd_o == 6'(31 + i)) else value_error("alloc order", 31 + i, prd_o);
        end
        rename_instr(5'd9, 5'd10, 5'd0, 1'b1, 1'b0);
        assert (prd_o == '0) else value_error("x0 prd", 0, prd_o);

        test_name = "dependency";
        rename_instr(5'd1, 5'd2, 5'd10, 1'b1, 1'b0);
        first_after = map_m[5'd10];
        rename_instr(5'd10, 5'd1, 5'd11, 1'b1, 1'b0);
        assert (prs1_o == first_after) else value_error("forwarded prs1", first_after, prs1_o);

        test_name = "random_complete";
        complete_all();

        test_name = "recycle";
        for (int i = 0; i < GL_DEPTH; i++) begin
            rename_instr(5'(i % 31 + 1), 5'(i), 5'(i % 31 + 1), 1'b1, 1'b0);
        end
        expect_stalled("ready at full list", 5'd1, 1'b0);
        complete_all();
        for (int i = 0; i < 12; i++) begin
            rename_instr(5'(i + 2), 5'(i + 1), 5'(i % 5 + 1), 1'b1, 1'b0);
        end
        complete_all();

        test_name = "mispredict";
        rename_instr(5'd1, 5'd2, 5'd3, 1'b1, 1'b0);
        rename_instr(5'd3, 5'd0, 5'd7, 1'b1, 1'b1);
        first_after = fl_m[fl_head_m];
        rename_instr(5'd3, 5'd7, 5'd3, 1'b1, 1'b0);
        rename_instr(5'd3, 5'd0, 5'd4, 1'b1, 1'b0);
        rename_instr(5'd4, 5'd3, 5'd5, 1'b1, 1'b0);
        resolve_branch(1'b1);
        rename_instr(5'd3, 5'd7, 5'd6, 1'b1, 1'b0);
        assert (prd_o == first_after) else value_error("restored head", first_after, prd_o);
        complete_all();

        test_name = "checkpoints";
        for (int i = 0; i < 4; i++) begin
            rename_instr(5'(i + 1), 5'(i + 2), 5'(i + 12), 1'b1, 1'b1);
            rename_instr(5'(i + 12), 5'd0, 5'(i + 20), 1'b1, 1'b0);
        end
        expect_stalled("ready without checkpoint", 5'd0, 1'b1);
        resolve_branch(1'b0);
        rename_instr(5'd1, 5'd2, 5'd0, 1'b0, 1'b1);
        repeat (4) resolve_branch(1'b0);
        complete_all();

        if (i_rename_core.i_rename_core_props.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("A port property of the DUT failed");
        end
    end

endmodule

`default_nettype wire
